// File: hw/l1d_geometry_pkg.sv
package l1d_geometry_pkg;

	////////////////////
	// cache shape
	////////////////////
	localparam int TAG_WIDTH = 21;
	localparam int SET_INDEX_WIDTH = 5;
	localparam int NUM_WAYS = 4;
	localparam int WORD_SELECT_WIDTH = 4;
	localparam int NUM_SETS = 1 << SET_INDEX_WIDTH;
	localparam int NUM_STRANDS = 4;

	// 16 words of 32 bits per line
	localparam int WORD_WIDTH = 32;
	localparam int LINE_WIDTH = WORD_WIDTH << WORD_SELECT_WIDTH;

	////////////////////
	// types
	////////////////////
	typedef logic [TAG_WIDTH - 1:0] tag_t;
	typedef logic [SET_INDEX_WIDTH - 1:0] set_index_t;
	typedef logic [$clog2(NUM_WAYS) - 1:0] way_index_t;
	typedef logic [LINE_WIDTH - 1:0] line_t;
	typedef logic [WORD_WIDTH - 1:0] word_t;
	typedef logic [$clog2(NUM_STRANDS) - 1:0] strand_t;

endpackage

// File: hw/l2_bus_pkg.sv
package l2_bus_pkg;

	////////////////////
	// opcodes
	////////////////////
	typedef logic [1:0] l2_op_t;

	localparam l2_op_t L2_OP_LOAD = 2'd0;

	////////////////////
	// request id
	////////////////////
	// unit number in the top bits, entry in the low bits
	localparam int L2_ID_UNIT_WIDTH = 2;
	localparam int L2_ID_ENTRY_WIDTH = 2;

	typedef logic [L2_ID_UNIT_WIDTH + L2_ID_ENTRY_WIDTH - 1:0] l2_id_t;

	// one enable bit per byte of a line
	localparam int L2_MASK_WIDTH = l1d_geometry_pkg::LINE_WIDTH / 8;

	////////////////////
	// line address
	////////////////////
	localparam int L2_ADDRESS_WIDTH = l1d_geometry_pkg::TAG_WIDTH
		+ l1d_geometry_pkg::SET_INDEX_WIDTH;

	typedef union packed {
		logic [L2_ADDRESS_WIDTH - 1:0] raw;
		struct packed {
			l1d_geometry_pkg::tag_t tag;
			l1d_geometry_pkg::set_index_t set_index;
		} fields;
	} l2_address_t;

endpackage

// File: hw/l2_bus_if.sv
`timescale 1ns/1ps

interface l2_bus_if;
	import l1d_geometry_pkg::*;
	import l2_bus_pkg::*;

	// request side
	logic pci_valid;
	logic pci_ack;
	l2_id_t pci_id;
	l2_op_t pci_op;
	way_index_t pci_way;
	l2_address_t pci_address;
	line_t pci_data;
	logic [L2_MASK_WIDTH - 1:0] pci_mask;

	// response side
	logic cpi_valid;
	l2_id_t cpi_id;
	l2_op_t cpi_op;
	logic cpi_allocate;
	way_index_t cpi_way;
	line_t cpi_data;

	modport requester(
		output pci_valid, pci_id, pci_op, pci_way, pci_address, pci_data, pci_mask,
		input pci_ack, cpi_valid, cpi_id, cpi_op, cpi_allocate, cpi_way, cpi_data);

	modport monitor(
		input cpi_valid, cpi_id, cpi_op, cpi_allocate, cpi_way, cpi_data);

endinterface

// File: hw/l1d_tag_array.sv
`timescale 1ns/1ps

module l1d_tag_array
	(input clk,
	input reset_i,
	input lookup_valid_i,
	input l2_bus_pkg::l2_address_t lookup_addr_i,
	output logic hit_o,
	output l1d_geometry_pkg::way_index_t hit_way_o,
	output logic free_o,
	output l1d_geometry_pkg::way_index_t free_way_o,
	input fill_i,
	input l2_bus_pkg::l2_address_t fill_addr_i,
	input l1d_geometry_pkg::way_index_t fill_way_i);

	import l1d_geometry_pkg::*;

	logic [NUM_WAYS - 1:0] valid [NUM_SETS];
	tag_t tags [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS - 1:0] way_match;
	set_index_t lookup_set;

	assign lookup_set = lookup_addr_i.fields.set_index;

	////////////////////
	// lookup
	////////////////////
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			way_match[w] = valid[lookup_set][w]
				&& tags[lookup_set][w] == lookup_addr_i.fields.tag;
			if (way_match[w])
				hit_way_o = way_index_t'(w);
		end

		hit_o = lookup_valid_i && |way_match;
	end

	// lowest empty way wins
	always_comb
	begin
		free_o = 1'b0;
		free_way_o = '0;
		for (int w = NUM_WAYS - 1; w >= 0; w--)
		begin
			if (!valid[lookup_set][w])
			begin
				free_o = 1'b1;
				free_way_o = way_index_t'(w);
			end
		end
	end

	////////////////////
	// fill
	////////////////////
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				valid[s] <= '0;
		end
		else if (fill_i)
			valid[fill_addr_i.fields.set_index][fill_way_i] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (fill_i)
			tags[fill_addr_i.fields.set_index][fill_way_i] <= fill_addr_i.fields.tag;
	end

endmodule

// File: hw/l1d_data_array.sv
`timescale 1ns/1ps

module l1d_data_array
	(input clk,
	input l1d_geometry_pkg::set_index_t read_set_i,
	input l1d_geometry_pkg::way_index_t read_way_i,
	output l1d_geometry_pkg::line_t read_line_o,
	input fill_i,
	input l1d_geometry_pkg::set_index_t fill_set_i,
	input l1d_geometry_pkg::way_index_t fill_way_i,
	l2_bus_if.monitor l2);

	import l1d_geometry_pkg::*;

	line_t lines [NUM_SETS][NUM_WAYS];

	// line comes straight off the fill response
	always_ff @(posedge clk)
	begin
		if (fill_i)
			lines[fill_set_i][fill_way_i] <= l2.cpi_data;
	end

	// registered read, one cycle after the address
	always_ff @(posedge clk)
	begin
		read_line_o <= lines[read_set_i][read_way_i];
	end

endmodule

// File: hw/lru_victim.sv
`timescale 1ns/1ps

module lru_victim
	(input clk,
	input reset_i,
	input access_i,
	input l1d_geometry_pkg::set_index_t access_set_i,
	input l1d_geometry_pkg::way_index_t access_way_i,
	input l1d_geometry_pkg::set_index_t set_i,
	input free_i,
	input l1d_geometry_pkg::way_index_t free_way_i,
	output l1d_geometry_pkg::way_index_t victim_way_o);

	import l1d_geometry_pkg::*;

	// bit 0 root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
	logic [NUM_WAYS - 2:0] tree [NUM_SETS];
	logic [NUM_WAYS - 2:0] cur_tree;

	assign cur_tree = tree[set_i];

	always_comb
	begin
		if (free_i)
			victim_way_o = free_way_i;
		else if (!cur_tree[0])
			victim_way_o = {1'b0, cur_tree[1]};
		else
			victim_way_o = {1'b1, cur_tree[2]};
	end

	////////////////////
	// update on hit or fill
	////////////////////
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int s = 0; s < NUM_SETS; s++)
				tree[s] <= '0;
		end
		else if (access_i)
		begin
			// point away from the way just touched
			tree[access_set_i][0] <= ~access_way_i[1];
			if (access_way_i[1])
				tree[access_set_i][2] <= ~access_way_i[0];
			else
				tree[access_set_i][1] <= ~access_way_i[0];
		end
	end

endmodule

// File: hw/load_miss_queue.sv
`timescale 1ns/1ps

module load_miss_queue
	#(parameter logic [l2_bus_pkg::L2_ID_UNIT_WIDTH - 1:0] L1D_UNIT_ID = 1)
	(input clk,
	input reset_i,
	input request_i,
	input l2_bus_pkg::l2_address_t miss_addr_i,
	input l1d_geometry_pkg::way_index_t victim_way_i,
	input l1d_geometry_pkg::strand_t strand_i,
	output logic [l1d_geometry_pkg::NUM_STRANDS - 1:0] load_complete_o,
	output l2_bus_pkg::l2_address_t load_complete_addr_o,
	output l1d_geometry_pkg::way_index_t load_complete_way_o,
	l2_bus_if.requester l2);

	import l1d_geometry_pkg::*;
	import l2_bus_pkg::*;

	localparam logic [1:0] STATE_IDLE = 2'd0;
	localparam logic [1:0] STATE_WAIT_L2_ACK = 2'd1;
	localparam logic [1:0] STATE_L2_ISSUED = 2'd2;

	logic [1:0] state_q;
	logic [1:0] state_nxt;
	l2_address_t miss_addr_q;
	way_index_t miss_way_q;
	strand_t miss_strand_q;
	logic fill_match;

	////////////////////
	// request
	////////////////////
	assign l2.pci_valid = state_q == STATE_WAIT_L2_ACK;
	assign l2.pci_id = {L1D_UNIT_ID, {L2_ID_ENTRY_WIDTH{1'b0}}};
	assign l2.pci_op = L2_OP_LOAD;
	assign l2.pci_way = miss_way_q;
	assign l2.pci_address = miss_addr_q;
	assign l2.pci_data = '0;
	assign l2.pci_mask = '0;

	// only our own load fills, and only after the ack
	assign fill_match = state_q == STATE_L2_ISSUED && l2.cpi_valid
		&& l2.cpi_id[$bits(l2_id_t) - 1 -: L2_ID_UNIT_WIDTH] == L1D_UNIT_ID
		&& l2.cpi_op == L2_OP_LOAD;

	assign load_complete_o = fill_match ? NUM_STRANDS'(1) << miss_strand_q : '0;
	assign load_complete_addr_o = miss_addr_q;
	assign load_complete_way_o = miss_way_q;

	always_ff @(posedge clk)
	begin
		if (request_i && state_q == STATE_IDLE)
		begin
			miss_addr_q <= miss_addr_i;
			miss_way_q <= victim_way_i;
			miss_strand_q <= strand_i;
		end
	end

	////////////////////
	// FSM
	////////////////////
	always_comb
	begin
		state_nxt = state_q;
		case (state_q)
			STATE_IDLE:
			begin
				if (request_i)
					state_nxt = STATE_WAIT_L2_ACK;
			end

			STATE_WAIT_L2_ACK:
			begin
				if (l2.pci_ack)
					state_nxt = STATE_L2_ISSUED;
			end

			STATE_L2_ISSUED:
			begin
				if (fill_match)
					state_nxt = STATE_IDLE;
			end

			default:
				state_nxt = STATE_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			state_q <= STATE_IDLE;
		else
			state_q <= state_nxt;
	end

endmodule

// File: hw/l1d_cache.sv
`timescale 1ns/1ps

module l1d_cache
	#(parameter logic [l2_bus_pkg::L2_ID_UNIT_WIDTH - 1:0] L1D_UNIT_ID = 1)
	(input clk,
	input reset_i,

	// core loads
	input load_valid_i,
	input l1d_geometry_pkg::strand_t load_strand_i,
	input [l2_bus_pkg::L2_ADDRESS_WIDTH + l1d_geometry_pkg::WORD_SELECT_WIDTH - 1:0] load_addr_i,
	output logic load_ready_o,
	output logic load_done_o,
	output l1d_geometry_pkg::strand_t load_done_strand_o,
	output l1d_geometry_pkg::word_t load_data_o,

	// level-2 request
	output logic pci_valid_o,
	input pci_ack_i,
	output l2_bus_pkg::l2_id_t pci_id_o,
	output l2_bus_pkg::l2_op_t pci_op_o,
	output l1d_geometry_pkg::way_index_t pci_way_o,
	output l2_bus_pkg::l2_address_t pci_address_o,
	output l1d_geometry_pkg::line_t pci_data_o,
	output logic [l2_bus_pkg::L2_MASK_WIDTH - 1:0] pci_mask_o,

	// level-2 response
	input cpi_valid_i,
	input l2_bus_pkg::l2_id_t cpi_id_i,
	input l2_bus_pkg::l2_op_t cpi_op_i,
	input cpi_allocate_i,
	input l1d_geometry_pkg::way_index_t cpi_way_i,
	input l1d_geometry_pkg::line_t cpi_data_i);

	import l1d_geometry_pkg::*;
	import l2_bus_pkg::*;

	l2_bus_if l2();

	l2_address_t core_addr;
	logic [WORD_SELECT_WIDTH - 1:0] core_word_sel;
	logic load_accept;
	logic hit;
	logic miss_accept;
	way_index_t hit_way;
	logic free;
	way_index_t free_way;
	way_index_t victim_way;
	logic [NUM_STRANDS - 1:0] load_complete;
	l2_address_t fill_addr;
	way_index_t fill_way;
	logic fill_done;
	strand_t fill_strand;
	line_t read_line;
	logic lru_access;
	set_index_t lru_set;
	way_index_t lru_way;
	logic result_from_fill;
	logic [WORD_SELECT_WIDTH - 1:0] result_word_sel;
	logic [WORD_SELECT_WIDTH - 1:0] miss_word_sel;
	word_t fill_word;

	////////////////////
	// bus breakout
	////////////////////
	assign pci_valid_o = l2.pci_valid;
	assign pci_id_o = l2.pci_id;
	assign pci_op_o = l2.pci_op;
	assign pci_way_o = l2.pci_way;
	assign pci_address_o = l2.pci_address;
	assign pci_data_o = l2.pci_data;
	assign pci_mask_o = l2.pci_mask;
	assign l2.pci_ack = pci_ack_i;
	assign l2.cpi_valid = cpi_valid_i;
	assign l2.cpi_id = cpi_id_i;
	assign l2.cpi_op = cpi_op_i;
	assign l2.cpi_allocate = cpi_allocate_i;
	assign l2.cpi_way = cpi_way_i;
	assign l2.cpi_data = cpi_data_i;

	always_comb
	begin
		core_addr.raw = load_addr_i[$bits(load_addr_i) - 1:WORD_SELECT_WIDTH];
		core_word_sel = load_addr_i[WORD_SELECT_WIDTH - 1:0];
	end

	assign load_accept = load_valid_i && load_ready_o;
	assign miss_accept = load_accept && !hit;
	assign fill_done = |load_complete;

	// hit and fill never touch the tree in the same cycle
	assign lru_access = hit || fill_done;
	assign lru_set = fill_done ? fill_addr.fields.set_index : core_addr.fields.set_index;
	assign lru_way = fill_done ? fill_way : hit_way;

	always_comb
	begin
		fill_strand = '0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			if (load_complete[s])
				fill_strand = strand_t'(s);
		end
	end

	l1d_tag_array tag_array(
		.clk(clk),
		.reset_i(reset_i),
		.lookup_valid_i(load_accept),
		.lookup_addr_i(core_addr),
		.hit_o(hit),
		.hit_way_o(hit_way),
		.free_o(free),
		.free_way_o(free_way),
		.fill_i(fill_done),
		.fill_addr_i(fill_addr),
		.fill_way_i(fill_way));

	l1d_data_array data_array(
		.clk(clk),
		.read_set_i(core_addr.fields.set_index),
		.read_way_i(hit_way),
		.read_line_o(read_line),
		.fill_i(fill_done),
		.fill_set_i(fill_addr.fields.set_index),
		.fill_way_i(fill_way),
		.l2(l2.monitor));

	lru_victim lru(
		.clk(clk),
		.reset_i(reset_i),
		.access_i(lru_access),
		.access_set_i(lru_set),
		.access_way_i(lru_way),
		.set_i(core_addr.fields.set_index),
		.free_i(free),
		.free_way_i(free_way),
		.victim_way_o(victim_way));

	load_miss_queue #(.L1D_UNIT_ID(L1D_UNIT_ID)) miss_queue(
		.clk(clk),
		.reset_i(reset_i),
		.request_i(miss_accept),
		.miss_addr_i(core_addr),
		.victim_way_i(victim_way),
		.strand_i(load_strand_i),
		.load_complete_o(load_complete),
		.load_complete_addr_o(fill_addr),
		.load_complete_way_o(fill_way),
		.l2(l2.requester));

	////////////////////
	// result stage
	////////////////////
	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			load_done_o <= 1'b0;
			result_from_fill <= 1'b0;
			load_ready_o <= 1'b1;
		end
		else
		begin
			load_done_o <= hit || fill_done;
			result_from_fill <= fill_done;
			if (miss_accept)
				load_ready_o <= 1'b0;
			else if (result_from_fill)
				load_ready_o <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (miss_accept)
			miss_word_sel <= core_word_sel;

		if (hit)
		begin
			load_done_strand_o <= load_strand_i;
			result_word_sel <= core_word_sel;
		end
		else if (fill_done)
		begin
			load_done_strand_o <= fill_strand;
			fill_word <= cpi_data_i[miss_word_sel * WORD_WIDTH +: WORD_WIDTH];
		end
	end

	// hit word comes from the registered array read
	assign load_data_o = result_from_fill ? fill_word
		: read_line[result_word_sel * WORD_WIDTH +: WORD_WIDTH];

endmodule

// File: sim/l1d_cache_props.sv
`timescale 1ns/1ps

module l1d_cache_props
	(input clk,
	input reset_i,
	input pci_valid,
	input pci_ack,
	input l2_bus_pkg::l2_id_t pci_id,
	input l2_bus_pkg::l2_op_t pci_op,
	input l1d_geometry_pkg::way_index_t pci_way,
	input l2_bus_pkg::l2_address_t pci_address,
	input [l1d_geometry_pkg::NUM_STRANDS - 1:0] load_complete);

	int error_count = 0;
	logic issued;

	// set between the ack and the completion
	always_ff @(posedge clk)
	begin
		if (reset_i)
			issued <= 1'b0;
		else if (pci_valid && pci_ack)
			issued <= 1'b1;
		else if (|load_complete)
			issued <= 1'b0;
	end

	////////////////////
	// request protocol
	////////////////////
	hold_until_ack: assert property (@(posedge clk) disable iff (reset_i)
		pci_valid && !pci_ack |=> pci_valid && $stable(pci_id) && $stable(pci_op)
			&& $stable(pci_way) && $stable(pci_address))
	else
	begin
		$error("request dropped or changed before its ack");
		error_count++;
	end

	drop_after_ack: assert property (@(posedge clk) disable iff (reset_i)
		pci_valid && pci_ack |=> !pci_valid)
	else
	begin
		$error("request still valid the cycle after its ack");
		error_count++;
	end

	single_request: assert property (@(posedge clk) disable iff (reset_i)
		issued |-> !pci_valid)
	else
	begin
		$error("second request while one is outstanding");
		error_count++;
	end

	// a completion needs an acked request and names one strand
	complete_onehot: assert property (@(posedge clk) disable iff (reset_i)
		|load_complete |-> $onehot(load_complete) && issued)
	else
	begin
		$error("completion without an acked request or naming more than one strand");
		error_count++;
	end

endmodule

bind load_miss_queue l1d_cache_props props_i(
	.clk(clk),
	.reset_i(reset_i),
	.pci_valid(l2.pci_valid),
	.pci_ack(l2.pci_ack),
	.pci_id(l2.pci_id),
	.pci_op(l2.pci_op),
	.pci_way(l2.pci_way),
	.pci_address(l2.pci_address),
	.load_complete(load_complete_o));

// File: sim/l1d_cache_tb.sv
`timescale 1ns/1ps

module l1d_cache_tb;
	import l1d_geometry_pkg::*;
	import l2_bus_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_LOADS = 400;
	localparam int DIRECTED_LOADS = 10;
	// accept, ack wait, fill wait, result and ready with some margin
	localparam int WORST_LOAD_CYCLES = 16;
	localparam logic [1:0] UNIT_ID = 2'd1;

	logic clk;
	logic reset_i;
	logic load_valid_i;
	strand_t load_strand_i;
	logic [L2_ADDRESS_WIDTH + WORD_SELECT_WIDTH - 1:0] load_addr_i;
	logic load_ready_o;
	logic load_done_o;
	strand_t load_done_strand_o;
	word_t load_data_o;
	logic pci_valid_o;
	logic pci_ack_i;
	l2_id_t pci_id_o;
	l2_op_t pci_op_o;
	way_index_t pci_way_o;
	l2_address_t pci_address_o;
	line_t pci_data_o;
	logic [L2_MASK_WIDTH - 1:0] pci_mask_o;
	logic cpi_valid_i;
	l2_id_t cpi_id_i;
	l2_op_t cpi_op_i;
	logic cpi_allocate_i;
	way_index_t cpi_way_i;
	line_t cpi_data_i;

	logic [31:0] lfsr;
	tag_t tag_pool [8];
	set_index_t set_pool [4];
	int hits;
	int misses;
	int evictions;

	// reference model state
	logic [NUM_WAYS - 1:0] model_valid [NUM_SETS];
	tag_t model_tag [NUM_SETS][NUM_WAYS];
	logic tree_root [NUM_SETS];
	logic tree_low [NUM_SETS];
	logic tree_high [NUM_SETS];

	l1d_cache #(.L1D_UNIT_ID(UNIT_ID)) l1d_cache_i(
		.clk(clk),
		.reset_i(reset_i),
		.load_valid_i(load_valid_i),
		.load_strand_i(load_strand_i),
		.load_addr_i(load_addr_i),
		.load_ready_o(load_ready_o),
		.load_done_o(load_done_o),
		.load_done_strand_o(load_done_strand_o),
		.load_data_o(load_data_o),
		.pci_valid_o(pci_valid_o),
		.pci_ack_i(pci_ack_i),
		.pci_id_o(pci_id_o),
		.pci_op_o(pci_op_o),
		.pci_way_o(pci_way_o),
		.pci_address_o(pci_address_o),
		.pci_data_o(pci_data_o),
		.pci_mask_o(pci_mask_o),
		.cpi_valid_i(cpi_valid_i),
		.cpi_id_i(cpi_id_i),
		.cpi_op_i(cpi_op_i),
		.cpi_allocate_i(cpi_allocate_i),
		.cpi_way_i(cpi_way_i),
		.cpi_data_i(cpi_data_i));

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(CLK_PERIOD * (NUM_LOADS * WORST_LOAD_CYCLES + 10));
		$display("timeout: the loads did not finish before the watchdog expired");
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////
	// helpers
	////////////////////
	// taps 32 22 2 1
	function automatic logic [31:0] random_bits(int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic word_t rule_word(logic [L2_ADDRESS_WIDTH - 1:0] line_addr, int k);
		return {2'b00, line_addr, 4'(k)};
	endfunction

	function automatic line_t rule_line(logic [L2_ADDRESS_WIDTH - 1:0] line_addr);
		line_t line;
		for (int k = 0; k < 16; k++)
			line[k * WORD_WIDTH +: WORD_WIDTH] = rule_word(line_addr, k);
		return line;
	endfunction

	task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("Regression failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// empty ways first, then follow the tree
	function automatic way_index_t predict_victim(set_index_t set_idx);
		for (int w = 0; w < NUM_WAYS; w++)
			if (!model_valid[set_idx][w])
				return way_index_t'(w);
		if (tree_root[set_idx])
			return {1'b1, tree_high[set_idx]};
		return {1'b0, tree_low[set_idx]};
	endfunction

	task automatic touch_tree(set_index_t set_idx, way_index_t way);
		tree_root[set_idx] = !way[1];
		if (way[1])
			tree_high[set_idx] = !way[0];
		else
			tree_low[set_idx] = !way[0];
	endtask

	task automatic send_response(l2_id_t id, l2_op_t op, line_t data);
		cpi_valid_i = 1'b1;
		cpi_id_i = id;
		cpi_op_i = op;
		cpi_allocate_i = 1'b1;
		cpi_way_i = '0;
		cpi_data_i = data;
	endtask

	////////////////////
	// level-2 responder
	////////////////////
	task automatic serve_miss(l2_address_t addr, way_index_t way);
		int ack_delay;
		int fill_delay;
		ack_delay = random_bits(2);
		fill_delay = random_bits(3) % 5 + 1;
		for (int c = 0; c <= ack_delay; c++)
		begin
			check_value("request valid", 1, pci_valid_o);
			check_value("request address", addr.raw, pci_address_o.raw);
			check_value("request id", {UNIT_ID, 2'b00}, pci_id_o);
			check_value("request opcode", L2_OP_LOAD, pci_op_o);
			check_value("request way", way, pci_way_o);
			check_value("request data", 0, |pci_data_o);
			check_value("request mask", 0, pci_mask_o);
			check_value("pending ready", 0, load_ready_o);
			// matching id but not yet acked, must be dropped
			if (random_bits(1))
				send_response({UNIT_ID, 2'b00}, L2_OP_LOAD, ~rule_line(addr.raw));
			else
				cpi_valid_i = 1'b0;
			pci_ack_i = (c == ack_delay);
			@(negedge clk);
			check_value("early done", 0, load_done_o);
		end
		pci_ack_i = 1'b0;
		cpi_valid_i = 1'b0;
		check_value("request drop", 0, pci_valid_o);
		for (int c = 1; c < fill_delay; c++)
		begin
			if (!random_bits(1))
				cpi_valid_i = 1'b0;
			else if (random_bits(1))
				send_response({UNIT_ID ^ 2'b10, 2'b00}, L2_OP_LOAD, ~rule_line(addr.raw));
			else
				send_response({UNIT_ID, 2'b00}, l2_op_t'(1 + random_bits(1)),
					~rule_line(addr.raw));
			@(negedge clk);
			check_value("stray done", 0, load_done_o);
		end
		send_response({UNIT_ID, 2'b00}, L2_OP_LOAD, rule_line(addr.raw));
		@(negedge clk);
		cpi_valid_i = 1'b0;
		check_value("fill done", 1, load_done_o);
		check_value("fill ready", 0, load_ready_o);
	endtask

	task automatic run_load(tag_t tag, set_index_t set_idx, logic [3:0] word_sel,
		strand_t strand);
		l2_address_t addr;
		logic hit;
		way_index_t way;
		addr.fields.tag = tag;
		addr.fields.set_index = set_idx;
		hit = 1'b0;
		way = predict_victim(set_idx);
		for (int w = 0; w < NUM_WAYS; w++)
		begin
			if (model_valid[set_idx][w] && model_tag[set_idx][w] == tag)
			begin
				hit = 1'b1;
				way = way_index_t'(w);
			end
		end
		while (!load_ready_o)
			@(negedge clk);
		load_valid_i = 1'b1;
		load_strand_i = strand;
		load_addr_i = {addr.raw, word_sel};
		@(negedge clk);
		load_valid_i = 1'b0;
		if (hit)
		begin
			hits++;
			check_value("hit done", 1, load_done_o);
			check_value("hit request", 0, pci_valid_o);
		end
		else
		begin
			misses++;
			if (&model_valid[set_idx])
				evictions++;
			check_value("miss done", 0, load_done_o);
			serve_miss(addr, way);
		end
		check_value("result strand", strand, load_done_strand_o);
		check_value("result data", rule_word(addr.raw, word_sel), load_data_o);
		touch_tree(set_idx, way);
		if (!hit)
		begin
			model_valid[set_idx][way] = 1'b1;
			model_tag[set_idx][way] = tag;
			@(negedge clk);
			check_value("ready after fill", 1, load_ready_o);
			check_value("single result", 0, load_done_o);
		end
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial
	begin
		int tag_idx;
		int set_sel;
		int word_sel;
		int strand;
		lfsr = 32'h2579;
		hits = 0;
		misses = 0;
		evictions = 0;
		for (int i = 0; i < 8; i++)
			tag_pool[i] = 21'h0B3C5 ^ (21'(i) << 17) ^ (21'(i) * 21'h0451);
		set_pool = '{5'd3, 5'd12, 5'd17, 5'd30};
		for (int s = 0; s < NUM_SETS; s++)
		begin
			model_valid[s] = '0;
			tree_root[s] = 1'b0;
			tree_low[s] = 1'b0;
			tree_high[s] = 1'b0;
		end

		reset_i = 1'b1;
		load_valid_i = 1'b0;
		load_strand_i = '0;
		load_addr_i = '0;
		pci_ack_i = 1'b0;
		cpi_valid_i = 1'b0;
		cpi_id_i = '0;
		cpi_op_i = '0;
		cpi_allocate_i = 1'b0;
		cpi_way_i = '0;
		cpi_data_i = '0;
		repeat (2)
			@(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		check_value("reset request", 0, pci_valid_o);
		check_value("reset done", 0, load_done_o);
		check_value("reset ready", 1, load_ready_o);

		// five tags in one set force an eviction, then revisit them
		for (int i = 0; i < DIRECTED_LOADS; i++)
			run_load(tag_pool[i % 5], set_pool[0], 4'(i), strand_t'(i));

		for (int i = DIRECTED_LOADS; i < NUM_LOADS; i++)
		begin
			tag_idx = random_bits(3);
			set_sel = random_bits(2);
			word_sel = random_bits(4);
			strand = random_bits(2);
			run_load(tag_pool[tag_idx], set_pool[set_sel], 4'(word_sel), strand_t'(strand));
		end
		repeat (2)
			@(negedge clk);

		assert (hits > 0 && misses > 0 && evictions > 0)
		else
		begin
			$display("stimulus did not reach a hit, a miss and an eviction");
			$display("Regression failed");
			$fatal(1, "coverage hole");
		end

		if (l1d_cache_i.miss_queue.props_i.error_count != 0)
		begin
			$display("level-2 request protocol assertions fired during the run");
			$display("Regression failed");
			$fatal(1, "protocol assertion failure");
		end
		else
		begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

// File: l1d_cache.f
hw/l1d_geometry_pkg.sv
hw/l2_bus_pkg.sv
hw/l2_bus_if.sv
hw/l1d_tag_array.sv
hw/l1d_data_array.sv
hw/lru_victim.sv
hw/load_miss_queue.sv
hw/l1d_cache.sv
sim/l1d_cache_props.sv
sim/l1d_cache_tb.sv
